// ==== build.f ====
src/boot_pkg.sv
src/spi_master.sv
src/sd_reader.sv
src/fpga_cfg.sv
src/boot_ctrl.sv
src/spi_boot.sv
sim/sd_card_model.sv
sim/tb_spi_boot.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_spi_boot
FILELIST   = build.f
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_spi_boot.sv ====
`timescale 1ns/1ps

module tb_spi_boot import boot_pkg::*; ();

   logic        clk = 1'b0;
   logic        rst;
   logic        spi_clk;
   logic        spi_cs_n;
   logic        spi_miso;
   logic        spi_mosi;
   logic        start;
   logic        mode;
   logic        detached;
   logic        dat_done;
   logic        config_n;
   logic        cfg_init_n = 1'b0;     // FPGA busy clearing at power-up
   logic        cfg_done   = 1'b0;
   logic        cfg_clk;
   logic        cfg_dat;
   logic [2:0]  busy_cnt;
   logic        cmd_stb;
   logic [5:0]  cmd_idx;
   logic [31:0] cmd_arg;
   logic        data_phase = 1'b0;
   logic        prog_seen  = 1'b0;     // config_n_o has been low
   logic        sck_d      = 1'b0;
   logic [7:0]  sh         = 8'h00;
   int          bit_n      = 0;
   int          n_bytes    = 0;        // Bytes taken off cfg_dat_o
   int          n_cmd      = 0;
   int          n_rd       = 0;        // CMD17 frames seen
   int          init_dly   = 0;
   int          init_left  = 0;
   int          done_left  = 128;      // FPGA startup after last byte
   int          errors     = 0;
   int          checks     = 0;
   int          tests      = 0;
   int          test_err   = 0;
   int          cycles     = 0;
   int          limit_cyc  = 3 * IMG_BYTES * (16 * SPI_DIV + 16) + 20000;

   always #4 clk = ~clk;

   spi_boot dut (
      .clk_i(clk), .rst_i(rst), .spi_clk_o(spi_clk), .spi_cs_n_o(spi_cs_n),
      .spi_data_in_i(spi_miso), .spi_data_out_o(spi_mosi), .start_i(start),
      .mode_i(mode), .detached_o(detached), .dat_done_i(dat_done),
      .config_n_o(config_n), .cfg_init_n_i(cfg_init_n), .cfg_done_i(cfg_done),
      .cfg_clk_o(cfg_clk), .cfg_dat_o(cfg_dat));

   sd_card_model card (
      .clk_i(clk), .rst_i(rst), .spi_clk_i(spi_clk), .spi_cs_n_i(spi_cs_n),
      .spi_mosi_i(spi_mosi), .spi_miso_o(spi_miso), .busy_cnt_i(busy_cnt),
      .cmd_stb_o(cmd_stb), .cmd_idx_o(cmd_idx), .cmd_arg_o(cmd_arg));

   function automatic logic [7:0] image_byte(input int a);
      return 8'(a ^ (a >> 8));
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_reset_state();
      check_val("spi_cs_n_o", 32'(spi_cs_n), 32'd1);
      check_val("spi_clk_o", 32'(spi_clk), 32'd0);
      check_val("config_n_o", 32'(config_n), 32'd1);
      check_val("cfg_clk_o", 32'(cfg_clk), 32'd0);
      check_val("detached_o", 32'(detached), 32'd0);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s, %0d errors", tests, name, errors - test_err);
      test_err = errors;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Monitors and FPGA model
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      if (cmd_stb) begin
         if (n_cmd == 0)
            check_val("cmd_idx", 32'(cmd_idx), 32'(CMD0));
         else if (n_cmd <= int'(busy_cnt) + 1)          // Busy answers, then ready
            check_val("cmd_idx", 32'(cmd_idx), 32'(CMD1));
         else begin
            check_val("cmd_idx", 32'(cmd_idx), 32'(CMD17));
            check_val("cmd_arg", cmd_arg, 32'(n_rd * BLOCK_BYTES));
            n_rd++;
         end
         n_cmd++;
      end
   end

   always @(posedge clk) begin
      if (cfg_clk && !sck_d) begin                      // CCLK rose last cycle
         sh = {sh[6:0], cfg_dat};
         bit_n++;
         if (bit_n == 8) begin
            check_val("cfg_dat_o byte", 32'(sh), 32'(image_byte(n_bytes)));
            n_bytes++;
            bit_n = 0;
         end
      end
      sck_d = cfg_clk;
   end

   always @(negedge clk) begin
      if (config_n === 1'b0) begin                      // Held in program
         prog_seen  <= 1'b1;
         cfg_init_n <= 1'b0;
         cfg_done   <= 1'b0;
         init_left  <= init_dly;
      end else if (!cfg_init_n && prog_seen) begin
         if (init_left == 0)
            cfg_init_n <= 1'b1;                         // Memory cleared
         else
            init_left <= init_left - 1;
      end else if (!data_phase && !cfg_done && n_bytes == IMG_BYTES) begin
         if (done_left == 0)
            cfg_done <= 1'b1;
         else
            done_left <= done_left - 1;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles == limit_cyc) begin
         $display("Run stopped after %0d cycles, a wait never ended", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   assert property (@(posedge clk) disable iff (rst) $rose(cfg_clk) |-> prog_seen && cfg_init_n)
      else begin
         errors++;
         $display("At %0t cfg_clk_o pulsed before the program pulse or during init", $time);
      end

   assert property (@(posedge clk) disable iff (rst) detached |-> spi_cs_n)
      else begin
         errors++;
         $display("At %0t the card was selected while detached_o was high", $time);
      end

   assert property (@(posedge clk) disable iff (rst) data_phase |-> config_n)
      else begin
         errors++;
         $display("At %0t config_n_o dropped during data mode", $time);
      end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(32'h50343fb0));
      rst      = 1'b1;
      start    = 1'b0;
      mode     = 1'b0;
      dat_done = 1'b0;
      busy_cnt = 3'($urandom % 5 + 1);                 // 1 to 5 idle answers
      init_dly = int'($urandom % 40) + 4;
      repeat (16) begin
         @(negedge clk);
         check_reset_state();
      end
      rst = 1'b0;
      @(negedge clk);
      check_reset_state();                              // First cycle out of reset
      end_test("reset state");

      while (n_rd == 0)
         @(negedge clk);
      check_val("command count", 32'(n_cmd), 32'(int'(busy_cnt) + 3));
      end_test("card bring-up");

      while (!cfg_done)
         @(negedge clk);
      check_val("prog pulse seen", 32'(prog_seen), 32'd1);
      end_test("configuration stream");

      while (!detached)
         @(negedge clk);
      repeat (200) @(negedge clk);                      // Idle, card released
      check_val("detached_o", 32'(detached), 32'd1);
      check_val("spi_cs_n_o", 32'(spi_cs_n), 32'd1);
      check_val("config byte count", 32'(n_bytes), 32'(IMG_BYTES));
      end_test("detach");

      data_phase = 1'b1;
      start      = 1'b1;
      mode       = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check_val("detached_o", 32'(detached), 32'd0);
      while (n_bytes < 2 * IMG_BYTES)
         @(negedge clk);
      repeat (128) @(negedge clk);                      // Requester wraps up
      check_val("detached_o", 32'(detached), 32'd0);   // Held until requester done
      dat_done = 1'b1;
      @(negedge clk);
      dat_done = 1'b0;
      while (!detached)
         @(negedge clk);
      check_val("CMD17 count", 32'(n_rd), 32'(2 * IMG_BLOCKS));
      check_val("data byte count", 32'(n_bytes), 32'(2 * IMG_BYTES));
      end_test("data mode");

      $display("%0d tests, %0d value checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== sim/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model import boot_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        spi_clk_i,
   input  logic        spi_cs_n_i,
   input  logic        spi_mosi_i,
   output logic        spi_miso_o,
   input  logic [2:0]  busy_cnt_i,     // CMD1 answers that still report idle
   output logic        cmd_stb_o,      // One cycle per decoded frame
   output logic [5:0]  cmd_idx_o,
   output logic [31:0] cmd_arg_o
);

   logic        sck_q;                 // SCK one system clock late
   logic [2:0]  rx_bit_q;
   logic [2:0]  tx_bit_q;
   logic [7:0]  rx_sh_q;
   logic [7:0]  tx_sh_q;              // Byte going out on MISO
   logic [2:0]  frm_cnt_q;            // Frame bytes so far
   logic [39:0] frm_q;
   logic [2:0]  busy_left;
   logic [7:0]  out_q[$];             // Response bytes, oldest first

   function automatic logic [7:0] image_byte(input logic [31:0] a);
      return a[7:0] ^ a[15:8];         // Low byte of a ^ (a >> 8)
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Responses queued behind a decoded command
   ////////////////////////////////////////////////////////////////////////////
   task automatic answer(input sd_cmd_u c);
      out_q.push_back(IDLE_BYTE);      // One byte of command latency
      case (c.f.idx)
         CMD0: begin
            busy_left = busy_cnt_i;
            out_q.push_back(R1_IDLE);
         end
         CMD1:
            if (busy_left != 3'd0) begin
               busy_left = busy_left - 3'd1;
               out_q.push_back(R1_IDLE);     // Still initializing
            end else begin
               out_q.push_back(R1_READY);
            end
         CMD17: begin
            out_q.push_back(R1_READY);
            out_q.push_back(IDLE_BYTE);      // Access time
            out_q.push_back(IDLE_BYTE);
            out_q.push_back(TOKEN_START);
            for (int i = 0; i < BLOCK_BYTES; i++)
               out_q.push_back(image_byte(c.f.arg + 32'(i)));
            out_q.push_back(8'hA5);          // CRC, never checked
            out_q.push_back(8'h5A);
         end
         default: out_q.push_back(8'h04);   // Illegal command
      endcase
   endtask

   always @(posedge clk_i) begin : card
      sd_cmd_u    cmd;
      logic [7:0] rx_byte;
      logic [7:0] nxt;
      cmd_stb_o <= 1'b0;
      sck_q     <= spi_clk_i;
      if (rst_i)
         out_q.delete();
      if (rst_i || spi_cs_n_i) begin    // Deselected, realign on bytes
         rx_bit_q   <= '0;
         tx_bit_q   <= '0;
         frm_cnt_q  <= '0;
         tx_sh_q    <= IDLE_BYTE;
         spi_miso_o <= 1'b1;
      end else if (spi_clk_i && !sck_q) begin         // Rising SCK
         rx_byte  = {rx_sh_q[6:0], spi_mosi_i};
         rx_sh_q  <= rx_byte;
         rx_bit_q <= rx_bit_q + 3'd1;
         if (rx_bit_q == 3'd7 && (frm_cnt_q != 3'd0 || rx_byte[7:6] == 2'b01)) begin
            frm_q     <= {frm_q[31:0], rx_byte};
            frm_cnt_q <= frm_cnt_q + 3'd1;
            if (frm_cnt_q == 3'd5) begin              // Frame complete
               cmd       = {frm_q, rx_byte};
               frm_cnt_q <= '0;
               cmd_stb_o <= 1'b1;
               cmd_idx_o <= cmd.f.idx;
               cmd_arg_o <= cmd.f.arg;
               answer(cmd);
            end
         end
      end else if (!spi_clk_i && sck_q) begin         // Falling SCK
         tx_bit_q <= tx_bit_q + 3'd1;
         if (tx_bit_q == 3'd7) begin
            nxt = IDLE_BYTE;
            if (out_q.size() != 0)
               nxt = out_q.pop_front();
            tx_sh_q    <= nxt;
            spi_miso_o <= nxt[7];                     // MSB ready before rise
         end else begin
            tx_sh_q    <= {tx_sh_q[6:0], 1'b1};
            spi_miso_o <= tx_sh_q[6];
         end
      end
   end

endmodule

// ==== src/spi_boot.sv ====
`timescale 1ns/1ps

module spi_boot import boot_pkg::*; (
   input  logic clk_i,
   input  logic rst_i,
   // Card side
   output logic spi_clk_o,
   output logic spi_cs_n_o,
   input  logic spi_data_in_i,
   output logic spi_data_out_o,
   // Data port
   input  logic start_i,
   input  logic mode_i,
   output logic detached_o,
   input  logic dat_done_i,
   // FPGA side
   output logic config_n_o,
   input  logic cfg_init_n_i,
   input  logic cfg_done_i,
   output logic cfg_clk_o,
   output logic cfg_dat_o
);

   img_req_t   req;                   // Controller to reader
   logic       req_ack;
   byte_strm_t strm;                  // Reader to shifter
   logic       strm_ready;
   logic       strm_done;
   logic       load_cfg;
   logic       xfer_start;            // Reader to SPI master
   logic       cs_assert;
   logic [7:0] tx_byte;
   logic [7:0] rx_byte;
   logic       xfer_done;

   boot_ctrl u_ctrl (
      .clk_i, .rst_i, .start_i, .mode_i, .dat_done_i, .cfg_done_i,
      .strm_done_i(strm_done), .req_o(req), .req_ack_i(req_ack),
      .load_cfg_o(load_cfg), .detached_o);

   sd_reader u_reader (
      .clk_i, .rst_i, .req_i(req), .req_ack_o(req_ack), .strm_o(strm),
      .strm_ready_i(strm_ready), .xfer_start_o(xfer_start), .cs_assert_o(cs_assert),
      .tx_byte_o(tx_byte), .rx_byte_i(rx_byte), .xfer_done_i(xfer_done));

   spi_master u_spi (
      .clk_i, .rst_i, .start_i(xfer_start), .cs_assert_i(cs_assert),
      .tx_byte_i(tx_byte), .rx_byte_o(rx_byte), .done_o(xfer_done),
      .spi_clk_o, .spi_cs_n_o, .spi_data_out_o, .spi_data_in_i);

   fpga_cfg u_cfg (
      .clk_i, .rst_i, .load_cfg_i(load_cfg), .strm_i(strm), .strm_ready_o(strm_ready),
      .strm_done_o(strm_done), .config_n_o, .cfg_init_n_i, .cfg_clk_o, .cfg_dat_o);

endmodule

// ==== src/boot_ctrl.sv ====
`timescale 1ns/1ps

module boot_ctrl import boot_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     start_i,
   input  logic     mode_i,           // 0 reconfigure, 1 data image
   input  logic     dat_done_i,
   input  logic     cfg_done_i,
   input  logic     strm_done_i,
   output img_req_t req_o,
   input  logic     req_ack_i,
   output logic     load_cfg_o,       // Pulse, program sequence first
   output logic     detached_o
);

   typedef enum logic [1:0] {B_CFG, B_ACK, B_WAIT, B_IDLE} state_e;

   state_e     state_q;
   logic       dat_mode_q;            // Image goes to the requester
   logic [1:0] dat_idx_q;             // Next data image on the card
   logic       strm_end_q;            // Last byte left the shifter
   logic       done_q;                // Requester said done

   always_ff @(posedge clk_i) begin
      load_cfg_o <= 1'b0;
      if (rst_i) begin
         state_q     <= B_CFG;        // Configure right after reset
         req_o.valid <= 1'b0;
         dat_mode_q  <= 1'b0;
         dat_idx_q   <= 2'd1;         // Image 0 holds the bitstream
         strm_end_q  <= 1'b0;
         done_q      <= 1'b0;
         detached_o  <= 1'b0;
      end else begin
         case (state_q)
            B_CFG: begin
               req_o      <= '{valid: 1'b1, idx: 2'd0};
               load_cfg_o <= 1'b1;
               dat_mode_q <= 1'b0;
               state_q    <= B_ACK;
            end
            B_ACK:
               if (req_ack_i) begin
                  req_o.valid <= 1'b0;
                  strm_end_q  <= 1'b0;
                  done_q      <= 1'b0;
                  state_q     <= B_WAIT;
               end
            B_WAIT: begin
               if (strm_done_i)
                  strm_end_q <= 1'b1;
               if (dat_done_i)
                  done_q <= 1'b1;     // May come as a short pulse
               // cfg_done_i is a level, only trusted after the stream ends
               if (strm_end_q && (dat_mode_q ? done_q : cfg_done_i)) begin
                  detached_o <= 1'b1;
                  state_q    <= B_IDLE;
               end
            end
            default:
               if (start_i) begin
                  detached_o <= 1'b0;
                  if (mode_i) begin
                     req_o      <= '{valid: 1'b1, idx: dat_idx_q};
                     dat_idx_q  <= dat_idx_q + 1'b1;
                     dat_mode_q <= 1'b1;
                     state_q    <= B_ACK;
                  end else begin
                     state_q <= B_CFG;      // Reload bitstream
                  end
               end
         endcase
      end
   end

endmodule

// ==== src/fpga_cfg.sv ====
`timescale 1ns/1ps

module fpga_cfg import boot_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       load_cfg_i,     // Start a program sequence
   input  byte_strm_t strm_i,
   output logic       strm_ready_o,
   output logic       strm_done_o,    // Pulse after last byte shifted
   output logic       config_n_o,     // PROG_B
   input  logic       cfg_init_n_i,
   output logic       cfg_clk_o,      // CCLK, also data mode clock
   output logic       cfg_dat_o
);

   typedef enum logic [1:0] {F_RUN, F_PROG, F_INIT} state_e;

   state_e     state_q;
   logic [2:0] cnt_q;                 // Pulse length, then bit index
   logic       busy_q;
   logic       last_q;                // Current byte ends the image
   logic [7:0] sh_q;

   assign strm_ready_o = (state_q == F_RUN) && !busy_q;

   always_ff @(posedge clk_i) begin
      strm_done_o <= 1'b0;
      if (rst_i) begin
         state_q    <= F_RUN;
         cnt_q      <= '0;
         busy_q     <= 1'b0;
         config_n_o <= 1'b1;
         cfg_clk_o  <= 1'b0;
      end else if (load_cfg_i) begin
         state_q    <= F_PROG;
         cnt_q      <= '0;            // Counts the cycles held low
         busy_q     <= 1'b0;
         config_n_o <= 1'b0;
         cfg_clk_o  <= 1'b0;
      end else begin
         case (state_q)
            F_PROG: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == 3'd7) begin   // 8 cycles low
                  config_n_o <= 1'b1;
                  state_q    <= F_INIT;
               end
            end
            F_INIT:
               if (cfg_init_n_i)          // FPGA cleared its memory
                  state_q <= F_RUN;
            default:
               if (strm_i.valid && strm_ready_o) begin
                  busy_q    <= 1'b1;
                  cnt_q     <= '0;
                  sh_q      <= strm_i.data;
                  cfg_dat_o <= strm_i.data[7];  // MSB first, clock low
                  last_q    <= strm_i.last;
               end else if (busy_q) begin
                  cfg_clk_o <= ~cfg_clk_o;
                  if (cfg_clk_o) begin           // Clock falls, next bit
                     cnt_q     <= cnt_q + 1'b1;
                     sh_q      <= {sh_q[6:0], 1'b0};
                     cfg_dat_o <= sh_q[6];
                     if (cnt_q == 3'd7) begin
                        busy_q      <= 1'b0;
                        strm_done_o <= last_q;
                     end
                  end
               end
         endcase
      end
   end

   // No CCLK edge while the FPGA is held in program
   assert property (@(posedge clk_i) disable iff (rst_i) $rose(cfg_clk_o) |-> config_n_o)
      else $error("fpga_cfg: cfg_clk_o pulsed with config_n_o low");

endmodule

// ==== src/sd_reader.sv ====
`timescale 1ns/1ps

module sd_reader import boot_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  img_req_t   req_i,
   output logic       req_ack_o,      // One cycle
   output byte_strm_t strm_o,
   input  logic       strm_ready_i,
   output logic       xfer_start_o,
   output logic       cs_assert_o,
   output logic [7:0] tx_byte_o,
   input  logic [7:0] rx_byte_i,
   input  logic       xfer_done_i
);

   typedef enum logic [2:0] {
      S_DUMMY, S_CMD, S_RESP, S_READY, S_TOKEN, S_DATA, S_CRC
   } state_e;

   state_e           state_q;
   logic             wait_q;          // Byte in flight on the SPI master
   logic [CNT_W-1:0] cnt_q;           // Byte index inside the phase
   logic [BLK_W-1:0] blk_q;           // Block inside the image
   sd_cmd_u          cmd_q;           // Frame being sent or answered

   function automatic sd_cmd_u make_cmd(input logic [5:0] idx, input logic [31:0] arg);
      sd_cmd_u c;
      c.f.st   = 2'b01;
      c.f.idx  = idx;
      c.f.arg  = arg;
      c.f.crc  = (idx == CMD0) ? CRC_CMD0 : CRC_NONE;
      c.f.stop = 1'b1;
      return c;
   endfunction

   always_ff @(posedge clk_i) begin
      xfer_start_o <= 1'b0;
      req_ack_o    <= 1'b0;
      if (rst_i) begin
         state_q      <= S_DUMMY;
         wait_q       <= 1'b0;
         cnt_q        <= '0;
         blk_q        <= '0;
         cs_assert_o  <= 1'b0;       // Dummy clocks with CS high
         strm_o.valid <= 1'b0;
      end else if (state_q == S_READY) begin
         if (req_i.valid) begin
            req_ack_o   <= 1'b1;
            cmd_q       <= make_cmd(CMD17, 32'(req_i.idx) * 32'(IMG_BYTES));
            blk_q       <= '0;
            cs_assert_o <= 1'b1;
            state_q     <= S_CMD;
         end
      end else if (strm_o.valid) begin     // Card clock paused here
         if (strm_ready_i) begin
            strm_o.valid <= 1'b0;
            cnt_q        <= cnt_q + 1'b1;  // Wraps to 0 after the block
            if (cnt_q == CNT_W'(BLOCK_BYTES - 1))
               state_q <= S_CRC;
         end
      end else if (!wait_q) begin          // Launch next byte
         xfer_start_o <= 1'b1;
         wait_q       <= 1'b1;
         tx_byte_o    <= (state_q == S_CMD) ? cmd_q.b[3'd5 - cnt_q[2:0]] : IDLE_BYTE;
      end else if (xfer_done_i) begin
         wait_q <= 1'b0;
         //////////////////////////////////////////////////////////////////////
         // Byte finished, act on it
         //////////////////////////////////////////////////////////////////////
         case (state_q)
            S_DUMMY: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == CNT_W'(DUMMY_BYTES - 1)) begin
                  cnt_q       <= '0;
                  cmd_q       <= make_cmd(CMD0, '0);
                  cs_assert_o <= 1'b1;
                  state_q     <= S_CMD;
               end
            end
            S_CMD: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == CNT_W'(5)) begin
                  cnt_q   <= '0;
                  state_q <= S_RESP;
               end
            end
            S_RESP: if (rx_byte_i != IDLE_BYTE) begin
               state_q <= S_CMD;               // Same frame again unless moved on
               case (cmd_q.f.idx)
                  CMD0:
                     if (rx_byte_i == R1_IDLE)
                        cmd_q <= make_cmd(CMD1, '0);
                  CMD1:
                     if (rx_byte_i == R1_READY) begin
                        cs_assert_o <= 1'b0;   // Card up, release it
                        state_q     <= S_READY;
                     end
                  default:
                     if (rx_byte_i == R1_READY)
                        state_q <= S_TOKEN;
               endcase
            end
            S_TOKEN:
               if (rx_byte_i == TOKEN_START)
                  state_q <= S_DATA;
            S_DATA: begin
               strm_o.valid <= 1'b1;
               strm_o.data  <= rx_byte_i;
               strm_o.last  <= (blk_q == BLK_W'(IMG_BLOCKS - 1)) &&
                               (cnt_q == CNT_W'(BLOCK_BYTES - 1));
            end
            S_CRC: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q[0]) begin             // Second CRC byte dropped
                  cnt_q   <= '0;
                  blk_q   <= blk_q + 1'b1;
                  cmd_q   <= make_cmd(CMD17, cmd_q.f.arg + 32'(BLOCK_BYTES));
                  state_q <= S_CMD;
                  if (blk_q == BLK_W'(IMG_BLOCKS - 1)) begin
                     cs_assert_o <= 1'b0;
                     state_q     <= S_READY;
                  end
               end
            end
            default: ;
         endcase
      end
   end

   // Byte must hold while the shifter is busy
   assert property (@(posedge clk_i) disable iff (rst_i)
      strm_o.valid && !strm_ready_i |=>
         strm_o.valid && $stable(strm_o.data) && $stable(strm_o.last))
      else $error("sd_reader: stream byte changed under back-pressure");

endmodule

// ==== src/spi_master.sv ====
`timescale 1ns/1ps

module spi_master import boot_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       start_i,        // One byte, ignored while busy
   input  logic       cs_assert_i,    // Hold card selected
   input  logic [7:0] tx_byte_i,
   output logic [7:0] rx_byte_o,
   output logic       done_o,         // Pulse, rx_byte_o valid
   output logic       spi_clk_o,      // Mode 0, idles low
   output logic       spi_cs_n_o,
   output logic       spi_data_out_o,
   input  logic       spi_data_in_i
);

   logic             busy_q;
   logic [DIV_W-1:0] div_q;           // Half-period prescaler
   logic [3:0]       half_q;          // 16 half periods per byte
   logic [7:0]       sh_q;            // Tx leaves at top, rx enters at bottom
   logic             miso_q;          // Bit caught on rising SCK
   logic             tick;            // SCK edge this cycle

   assign tick           = busy_q && (div_q == DIV_W'(SPI_DIV - 1));
   assign rx_byte_o      = sh_q;
   assign spi_data_out_o = sh_q[7];   // MSB first

   always_ff @(posedge clk_i) begin
      done_o <= 1'b0;
      if (rst_i) begin
         busy_q     <= 1'b0;
         div_q      <= '0;
         half_q     <= '0;
         spi_clk_o  <= 1'b0;
         spi_cs_n_o <= 1'b1;          // Card released
      end else begin
         spi_cs_n_o <= ~cs_assert_i;
         if (start_i) begin
            busy_q <= 1'b1;
            div_q  <= '0;
            half_q <= '0;
            sh_q   <= tx_byte_i;      // Bit 7 on the line before first rise
         end else if (busy_q) begin
            div_q <= tick ? '0 : div_q + 1'b1;
            if (tick) begin
               spi_clk_o <= ~spi_clk_o;
               half_q    <= half_q + 1'b1;
               if (!spi_clk_o)
                  miso_q <= spi_data_in_i;       // Rising edge, sample
               else
                  sh_q <= {sh_q[6:0], miso_q};   // Falling edge, shift
               if (half_q == 4'd15) begin        // Last falling edge
                  busy_q <= 1'b0;
                  done_o <= 1'b1;
               end
            end
         end
      end
   end

   // Reader must wait for done before the next byte
   assert property (@(posedge clk_i) disable iff (rst_i) start_i |-> !busy_q)
      else $error("spi_master: start while a byte is in flight");

endmodule

// ==== src/boot_pkg.sv ====
package boot_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Image geometry and serial clock
   ////////////////////////////////////////////////////////////////////////////
   localparam int BLOCK_BYTES = 512;                      // One card block
   localparam int IMG_BLOCKS  = 4;                        // Blocks per image
   localparam int IMG_BYTES   = BLOCK_BYTES * IMG_BLOCKS; // 2048
   localparam int SPI_DIV     = 2;                        // Sys clocks per half SCK
   localparam int DUMMY_BYTES = 10;                       // 80 clocks at power-up
   localparam int CNT_W       = $clog2(BLOCK_BYTES);      // Byte counter width
   localparam int BLK_W       = $clog2(IMG_BLOCKS);       // Block counter width
   localparam int DIV_W       = $clog2(SPI_DIV);          // Prescaler width

   ////////////////////////////////////////////////////////////////////////////
   // Card command set and response codes
   ////////////////////////////////////////////////////////////////////////////
   localparam logic [5:0] CMD0        = 6'd0;   // GO_IDLE_STATE
   localparam logic [5:0] CMD1        = 6'd1;   // SEND_OP_COND
   localparam logic [5:0] CMD17       = 6'd17;  // READ_SINGLE_BLOCK
   localparam logic [6:0] CRC_CMD0    = 7'h4A;  // Only CRC the card checks
   localparam logic [6:0] CRC_NONE    = 7'h7F;  // Ignored once in SPI mode
   localparam logic [7:0] TOKEN_START = 8'hFE;  // Data start token
   localparam logic [7:0] R1_IDLE     = 8'h01;  // In idle state
   localparam logic [7:0] R1_READY    = 8'h00;  // Init done, no error
   localparam logic [7:0] IDLE_BYTE   = 8'hFF;  // Line high, no response

   // 48-bit command frame, built by fields, shifted out by bytes
   typedef union packed {
      struct packed {
         logic [1:0]  st;    // Start bit 0, transmit bit 1
         logic [5:0]  idx;   // Command index
         logic [31:0] arg;   // Byte address for CMD17
         logic [6:0]  crc;
         logic        stop;  // Always 1
      } f;
      logic [5:0][7:0] b;    // b[5] goes out first
   } sd_cmd_u;

   typedef struct packed {
      logic       valid;
      logic       last;      // Final byte of the image
      logic [7:0] data;
   } byte_strm_t;

   typedef struct packed {
      logic       valid;     // Held until acknowledged
      logic [1:0] idx;       // Image number on the card
   } img_req_t;

endpackage
